// ==== Bender.yml ====
package:
  name: emmu

dependencies: {}

sources:
  # package first, then the RTL from the leaf up
  - files:
      - source/emmu_pkg.sv
      - source/emmu_table.sv
      - source/emmu.sv
      - source/emmu_top.sv

  # bound checker before the testbench top
  - target: test
    files:
      - verif/emmu_assert.sv
      - verif/emmu_tb.sv

# top modules
#   RTL:        emmu_top
#   testbench:  emmu_tb

// ==== all.f ====
source/emmu_pkg.sv
source/emmu_table.sv
source/emmu.sv
source/emmu_top.sv
verif/emmu_assert.sv
verif/emmu_tb.sv

// ==== source/emmu.sv ====
//------------------------------
// one rd_clk of latency from access_in to access_out
// table writes to an entry must not overlap its lookups
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module emmu #(
   parameter int maw = 12                                   // index width
) (
   // clocks and reset
   input  wire                              reset,          // async, active high
   input  wire                              rd_clk,         // packet clock
   input  wire                              wr_clk,         // config clock
   // static controls
   input  wire                              mmu_en,         // apply translation
   input  wire                              mmu_bp,         // force pass through
   // configuration writes
   input  wire                              mi_en,
   input  wire                              mi_we,
   input  wire  [maw+2:0]                   mi_addr,        // [maw+2:3] entry, [2] word
   input  wire  [emmu_pkg::mi_data_w-1:0]   mi_din,
   // packet in
   input  wire                              emesh_access_in,
   input  wire  [emmu_pkg::pkt_w-1:0]       emesh_packet_in,
   input  wire                              emesh_wait_in,  // downstream pushback
   // packet out
   output logic                             emesh_access_out,
   output logic [emmu_pkg::pkt_w-1:0]       emesh_packet_out,
   output logic [emmu_pkg::hi_w-1:0]        emesh_packet_hi_out
);

   localparam int ent_w = maw + emmu_pkg::mi_data_w;        // table entry width
   localparam int off_w = emmu_pkg::addr_w - maw;           // page offset width
   localparam int out_w = emmu_pkg::hi_w + emmu_pkg::addr_w; // widened address
   localparam int dlsb  = emmu_pkg::dst_lsb;
   localparam int dmsb  = emmu_pkg::dst_msb;
   localparam int pmsb  = emmu_pkg::pkt_w - 1;

   // config decode
   logic                          wr_go;
   logic                          wr_en_lo;
   logic                          wr_en_hi;
   logic [maw-1:0]                wr_addr;

   // lookup side
   logic                          accept;
   logic [maw-1:0]                rd_addr;
   logic [ent_w-1:0]              lookup_data;

   // output stage
   logic [emmu_pkg::pkt_w-1:0]    packet_reg;
   logic [emmu_pkg::addr_w-1:0]   dst_reg;
   logic                          xlate_on;
   logic [out_w-1:0]              dstaddr_out;

   // write decode
   // mi_addr[1:0] is byte offset, not used
   assign wr_go    = mi_en & mi_we;                         // no write without we
   assign wr_en_lo = wr_go & ~mi_addr[2];                   // word 0, low 32 bits
   assign wr_en_hi = wr_go & mi_addr[2];                    // word 1, upper maw bits
   assign wr_addr  = mi_addr[maw+2:3];                      // entry select

   // lookup
   // a packet is taken only when downstream is not waiting
   assign accept  = emesh_access_in & ~emesh_wait_in;
   assign rd_addr = emesh_packet_in[dmsb -: maw];           // top index bits of dst

   emmu_table #(
      .maw      (maw)
   ) u_table (
      .wr_clk   (wr_clk),
      .wr_en_lo (wr_en_lo),
      .wr_en_hi (wr_en_hi),
      .wr_addr  (wr_addr),
      .wr_data  (mi_din),
      .rd_clk   (rd_clk),
      .rd_en    (accept),                                   // frozen under wait
      .rd_addr  (rd_addr),
      .rd_data  (lookup_data)
   );

   // output strobe
   // matches the one cycle table read
   always_ff @(posedge rd_clk or posedge reset) begin
      if (reset) begin
         emesh_access_out <= 1'b0;
      end else if (!emesh_wait_in) begin
         emesh_access_out <= emesh_access_in;
      end
   end

   // packet register
   // keeps the last accepted packet when idle or waiting
   always_ff @(posedge rd_clk) begin
      if (accept) begin
         packet_reg <= emesh_packet_in;
      end
   end

   assign dst_reg = packet_reg[dmsb:dlsb];                  // original destination

   // mmu_en and mmu_bp are static levels
   // they act directly on the output without a register
   assign xlate_on = mmu_en & ~mmu_bp;

   // widened address
   // translated form is entry bits then the untouched page offset
   always_comb begin
      if (xlate_on) begin
         dstaddr_out = {lookup_data, dst_reg[off_w-1:0]};
      end else begin
         dstaddr_out = {{emmu_pkg::hi_w{1'b0}}, dst_reg};  // zero upper part
      end
   end

   // rebuild the packet around the new destination
   assign emesh_packet_out = {packet_reg[pmsb:dmsb+1],      // data and source
                              dstaddr_out[emmu_pkg::addr_w-1:0],
                              packet_reg[dlsb-1:0]};        // control byte

   // upper address word leaves on the side port
   assign emesh_packet_hi_out = dstaddr_out[out_w-1:emmu_pkg::addr_w];

endmodule

`default_nettype wire

// ==== source/emmu_pkg.sv ====
//------------------------------
// packet layout of the mesh stream
// widths here assume a 32 bit address space
//------------------------------
`default_nettype none

package emmu_pkg;

   // full mesh packet
   parameter int pkt_w = 104;

   // destination address field inside the packet
   parameter int dst_lsb = 8;      // just above the control byte
   parameter int dst_msb = 39;     // top of the 32 bit destination

   // incoming destination address width
   // also the width that a translated entry is split into on the way out
   parameter int addr_w = 32;

   // upper half of the widened address, sent on its own port
   parameter int hi_w = 32;

   // configuration word width, one table half per write
   parameter int mi_data_w = 32;

   // packet bits [7:0] hold the control byte and pass through untouched
   // packet bits [103:40] hold data and source and pass through as well
   // only [39:8] is rewritten by the translation

endpackage

`default_nettype wire

// ==== source/emmu_table.sv ====
//------------------------------
// storage has no reset, unwritten entries read as x
// wr_clk and rd_clk are unrelated, no sync inside
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module emmu_table #(
   parameter int maw = 12                                 // entries = 2**maw
) (
   // write side, wr_clk domain
   input  wire                              wr_clk,
   input  wire                              wr_en_lo,     // write entry bits [31:0]
   input  wire                              wr_en_hi,     // write entry bits above 31
   input  wire  [maw-1:0]                   wr_addr,
   input  wire  [emmu_pkg::mi_data_w-1:0]   wr_data,
   // read side, rd_clk domain
   input  wire                              rd_clk,
   input  wire                              rd_en,
   input  wire  [maw-1:0]                   rd_addr,
   output logic [maw+emmu_pkg::mi_data_w-1:0] rd_data     // registered
);

   localparam int lo_w  = emmu_pkg::mi_data_w;            // word 0 width
   localparam int ent_w = maw + lo_w;                     // full entry width
   localparam int depth = 2 ** maw;

   // one row per translation entry
   logic [ent_w-1:0] mem [depth];

   // two halves written independently
   // word 1 only keeps the low maw bits of the config word
   always_ff @(posedge wr_clk) begin
      if (wr_en_lo) begin
         mem[wr_addr][lo_w-1:0] <= wr_data;               // word 0
      end
      if (wr_en_hi) begin
         mem[wr_addr][ent_w-1:lo_w] <= wr_data[maw-1:0];  // word 1
      end
   end

   // registered read
   // holds last entry while rd_en is low, that keeps the output
   // stage stable under wait
   always_ff @(posedge rd_clk) begin
      if (rd_en) begin
         rd_data <= mem[rd_addr];
      end
   end

endmodule

`default_nettype wire

// ==== source/emmu_top.sv ====
//------------------------------
// maw is fixed here for the subsystem
// valid for maw from 1 to 31
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module emmu_top #(
   parameter int maw = 12                                   // 4096 entries
) (
   // clocks and reset
   input  wire                              reset,
   input  wire                              rd_clk,
   input  wire                              wr_clk,
   // static controls
   input  wire                              mmu_en,
   input  wire                              mmu_bp,
   // configuration port, write only
   input  wire                              mi_en,
   input  wire                              mi_we,
   input  wire  [maw+2:0]                   mi_addr,
   input  wire  [emmu_pkg::mi_data_w-1:0]   mi_din,
   // mesh packet in
   input  wire                              emesh_access_in,
   input  wire  [emmu_pkg::pkt_w-1:0]       emesh_packet_in,
   input  wire                              emesh_wait_in,
   // mesh packet out, one rd_clk later
   output logic                             emesh_access_out,
   output logic [emmu_pkg::pkt_w-1:0]       emesh_packet_out,
   output logic [emmu_pkg::hi_w-1:0]        emesh_packet_hi_out
);

   // single translation group
   emmu #(
      .maw                 (maw)
   ) u_emmu (
      .reset               (reset),
      .rd_clk              (rd_clk),
      .wr_clk              (wr_clk),
      .mmu_en              (mmu_en),
      .mmu_bp              (mmu_bp),
      .mi_en               (mi_en),
      .mi_we               (mi_we),
      .mi_addr             (mi_addr),
      .mi_din              (mi_din),
      .emesh_access_in     (emesh_access_in),
      .emesh_packet_in     (emesh_packet_in),
      .emesh_wait_in       (emesh_wait_in),
      .emesh_access_out    (emesh_access_out),
      .emesh_packet_out    (emesh_packet_out),
      .emesh_packet_hi_out (emesh_packet_hi_out)            // upper 32 address bits
   );

endmodule

`default_nettype wire

// ==== verif/emmu_assert.sv ====
//------------------------------
// shadow table assumes no write overlaps a lookup of that entry
// unwritten shadow entries hold x
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module emmu_assert #(
   parameter int maw = 12
) (
   input wire                              reset,
   input wire                              rd_clk,
   input wire                              wr_clk,
   input wire                              mmu_en,
   input wire                              mmu_bp,
   input wire                              mi_en,
   input wire                              mi_we,
   input wire [maw+2:0]                    mi_addr,
   input wire [emmu_pkg::mi_data_w-1:0]    mi_din,
   input wire                              emesh_access_in,
   input wire [emmu_pkg::pkt_w-1:0]        emesh_packet_in,
   input wire                              emesh_wait_in,
   input wire                              emesh_access_out,
   input wire [emmu_pkg::pkt_w-1:0]        emesh_packet_out,
   input wire [emmu_pkg::hi_w-1:0]         emesh_packet_hi_out
);

   localparam int lo_w  = emmu_pkg::mi_data_w;              // word 0 width
   localparam int off_w = emmu_pkg::addr_w - maw;           // page offset width
   localparam int dlsb  = emmu_pkg::dst_lsb;
   localparam int dmsb  = emmu_pkg::dst_msb;
   localparam int pmsb  = emmu_pkg::pkt_w - 1;
   localparam int depth = 2 ** maw;

   logic [lo_w-1:0]              shadow_lo [depth];
   logic [maw-1:0]               shadow_hi [depth];
   logic [maw-1:0]               in_idx;
   logic [emmu_pkg::pkt_w-1:0]   pkt_q;                     // accepted packet
   logic [maw+lo_w-1:0]          ent_q;                     // its entry at lookup
   int                           fail_count = 0;

   // word 1 keeps only maw bits
   always @(posedge wr_clk) begin
      if (mi_en && mi_we) begin
         if (mi_addr[2]) begin
            shadow_hi[mi_addr[maw+2:3]] <= mi_din[maw-1:0];
         end else begin
            shadow_lo[mi_addr[maw+2:3]] <= mi_din;
         end
      end
   end

   assign in_idx = emesh_packet_in[dmsb -: maw];            // top of destination

   always @(posedge rd_clk) begin
      if (emesh_access_in && !emesh_wait_in) begin
         pkt_q <= emesh_packet_in;
         ent_q <= {shadow_hi[in_idx], shadow_lo[in_idx]};
      end
   end

   a_reset_quiet: assert property (@(posedge rd_clk) reset |-> !emesh_access_out)
      else begin
         $error("[ERROR] %0t ns access out high during reset", $time);
         fail_count = fail_count + 1;
      end

   a_latency: assert property (@(posedge rd_clk) disable iff (reset)
      (emesh_access_in && !emesh_wait_in) |=> emesh_access_out)
      else begin
         $error("[ERROR] %0t ns accepted access not seen one cycle later", $time);
         fail_count = fail_count + 1;
      end

   a_no_spurious: assert property (@(posedge rd_clk) disable iff (reset)
      (!emesh_access_in && !emesh_wait_in) |=> !emesh_access_out)
      else begin
         $error("[ERROR] %0t ns access out without an input access", $time);
         fail_count = fail_count + 1;
      end

   // entry bits then page offset
   a_translate: assert property (@(posedge rd_clk) disable iff (reset)
      (emesh_access_out && mmu_en && !mmu_bp) |->
      ({emesh_packet_hi_out, emesh_packet_out[dmsb:dlsb]} == {ent_q, pkt_q[dlsb +: off_w]}))
      else begin
         $error("[ERROR] %0t ns translated address differs from shadow entry", $time);
         fail_count = fail_count + 1;
      end

   a_bypass: assert property (@(posedge rd_clk) disable iff (reset)
      (emesh_access_out && (mmu_bp || !mmu_en)) |->
      (emesh_packet_out[dmsb:dlsb] == pkt_q[dmsb:dlsb] && emesh_packet_hi_out == '0))
      else begin
         $error("[ERROR] %0t ns untranslated destination or zero upper part wrong", $time);
         fail_count = fail_count + 1;
      end

   a_passthrough: assert property (@(posedge rd_clk) disable iff (reset)
      emesh_access_out |->
      (emesh_packet_out[pmsb:dmsb+1] == pkt_q[pmsb:dmsb+1] &&
       emesh_packet_out[dlsb-1:0] == pkt_q[dlsb-1:0]))
      else begin
         $error("[ERROR] %0t ns packet bits outside destination changed", $time);
         fail_count = fail_count + 1;
      end

   // output frozen for a cycle under wait, controls held steady
   a_wait_hold: assert property (@(posedge rd_clk) disable iff (reset)
      emesh_wait_in ##1 ($stable(mmu_en) && $stable(mmu_bp)) |->
      ($stable(emesh_access_out) && $stable(emesh_packet_out) &&
       $stable(emesh_packet_hi_out)))
      else begin
         $error("[ERROR] %0t ns output changed while wait was high", $time);
         fail_count = fail_count + 1;
      end

endmodule

bind emmu_top emmu_assert #(
   .maw                 (maw)
) u_assert (
   .reset               (reset),
   .rd_clk              (rd_clk),
   .wr_clk              (wr_clk),
   .mmu_en              (mmu_en),
   .mmu_bp              (mmu_bp),
   .mi_en               (mi_en),
   .mi_we               (mi_we),
   .mi_addr             (mi_addr),
   .mi_din              (mi_din),
   .emesh_access_in     (emesh_access_in),
   .emesh_packet_in     (emesh_packet_in),
   .emesh_wait_in       (emesh_wait_in),
   .emesh_access_out    (emesh_access_out),
   .emesh_packet_out    (emesh_packet_out),
   .emesh_packet_hi_out (emesh_packet_hi_out)
);

`default_nettype wire

// ==== verif/emmu_tb.sv ====
//------------------------------
// runs with maw of 12, every looked up entry is written first
// all result checks sit in the bound emmu_assert
//------------------------------
`timescale 1ns/1ps
`default_nettype none

module emmu_tb;

   localparam int maw         = 12;
   localparam int pkt_w       = emmu_pkg::pkt_w;
   localparam int off_w       = emmu_pkg::addr_w - maw;     // page offset bits
   localparam int n_fill      = 24;                         // entries used by lookups
   localparam int n_part      = 8;                          // single word rewrites
   localparam int n_per_phase = 40;                         // packets per phase
   localparam int n_writes    = 2 * n_fill + n_part + 1;    // +1 for the no-we cycle
   localparam int n_pkts      = 4 * n_per_phase;
   localparam int t_clk       = 20;
   localparam int timeout_ns  = (n_pkts + n_writes) * 4 * t_clk + 200 * t_clk;

   logic                              reset;
   logic                              rd_clk;
   logic                              wr_clk;
   logic                              mmu_en;
   logic                              mmu_bp;
   logic                              mi_en;
   logic                              mi_we;
   logic [maw+2:0]                    mi_addr;
   logic [emmu_pkg::mi_data_w-1:0]    mi_din;
   logic                              emesh_access_in;
   logic [pkt_w-1:0]                  emesh_packet_in;
   logic                              emesh_wait_in;
   logic                              emesh_access_out;
   logic [pkt_w-1:0]                  emesh_packet_out;
   logic [emmu_pkg::hi_w-1:0]         emesh_packet_hi_out;

   logic [31:0]                       rng;                  // xorshift state
   logic [maw-1:0]                    idx_list [n_fill];    // filled entries

   emmu_top #(
      .maw                 (maw)
   ) UUT (
      .reset               (reset),
      .rd_clk              (rd_clk),
      .wr_clk              (wr_clk),
      .mmu_en              (mmu_en),
      .mmu_bp              (mmu_bp),
      .mi_en               (mi_en),
      .mi_we               (mi_we),
      .mi_addr             (mi_addr),
      .mi_din              (mi_din),
      .emesh_access_in     (emesh_access_in),
      .emesh_packet_in     (emesh_packet_in),
      .emesh_wait_in       (emesh_wait_in),
      .emesh_access_out    (emesh_access_out),
      .emesh_packet_out    (emesh_packet_out),
      .emesh_packet_hi_out (emesh_packet_hi_out)
   );

   // rd_clk rises at 10, 30, ...
   initial rd_clk = 1'b0;
   always #10 rd_clk = ~rd_clk;

   // wr_clk rises 5 ns earlier
   always begin
      wr_clk = 1'b0;
      #5 wr_clk = 1'b1;
      #10 wr_clk = 1'b0;
      #5;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function logic [31:0] next_rand();
      rng = xorshift(rng);                                  // advance state
      return rng;
   endfunction

   // one config cycle, we low makes it a read-free no-op
   task automatic cfg_cycle(input logic [maw-1:0] entry, input logic word,
                            input logic we, input logic [31:0] data);
      @(posedge wr_clk);
      #1;
      mi_en   = 1'b1;
      mi_we   = we;
      mi_addr = {entry, word, 2'b00};                       // byte offset left at 0
      mi_din  = data;
      @(posedge wr_clk);
      #1;
      mi_en   = 1'b0;
      mi_we   = 1'b0;
   endtask

   task automatic idle(input int n);
      emesh_access_in = 1'b0;
      repeat (n) begin
         @(posedge rd_clk);
         #1;
      end
   endtask

   // packet held until an edge with wait low takes it
   task automatic send_packet(input logic rand_wait);
      logic [pkt_w-1:0] pkt;
      logic [31:0]      r;
      logic             taken;
      r = next_rand();
      pkt[pkt_w-1:96] = r[pkt_w-97:0];
      pkt[95:64]      = next_rand();
      pkt[63:32]      = next_rand();
      pkt[31:0]       = next_rand();
      r = next_rand();
      pkt[emmu_pkg::dst_msb -: maw] = idx_list[r % n_fill];  // known entry only
      r = next_rand();
      pkt[emmu_pkg::dst_lsb +: off_w] = r[off_w-1:0];
      emesh_access_in = 1'b1;
      emesh_packet_in = pkt;
      do begin
         if (rand_wait) begin
            r = next_rand();
            emesh_wait_in = (r[2:0] < 3'd3);                // wait about 3 in 8
         end
         taken = ~emesh_wait_in;
         @(posedge rd_clk);
         #1;
      end while (!taken);
   endtask

   task automatic run_phase(input logic en, input logic bp, input logic rand_wait);
      logic [31:0] r;
      mmu_en = en;                                          // pipeline is empty here
      mmu_bp = bp;
      repeat (n_per_phase) begin
         send_packet(rand_wait);
         r = next_rand();
         if (r[2:0] == 3'd0) begin
            idle(1 + r[4:3]);                               // short gap in the stream
         end
      end
      emesh_wait_in = 1'b0;
      idle(3);                                              // drain
   endtask

   initial begin
      logic [31:0] r;
      rng             = 32'h1c5c_91d9;
      reset           = 1'b1;
      mmu_en          = 1'b0;
      mmu_bp          = 1'b0;
      mi_en           = 1'b0;
      mi_we           = 1'b0;
      mi_addr         = '0;
      mi_din          = '0;
      emesh_access_in = 1'b0;
      emesh_packet_in = '0;
      emesh_wait_in   = 1'b0;
      repeat (8) @(posedge rd_clk);
      #1 reset = 1'b0;
      // fill both words of each entry
      for (int i = 0; i < n_fill; i++) begin
         r = next_rand();
         idx_list[i] = r[maw-1:0];
         cfg_cycle(idx_list[i], 1'b0, 1'b1, next_rand());
         cfg_cycle(idx_list[i], 1'b1, 1'b1, next_rand());
      end
      // rewrite one word only, other word must survive
      for (int i = 0; i < n_part; i++) begin
         r = next_rand();
         cfg_cycle(idx_list[r % n_fill], r[31], 1'b1, next_rand());
      end
      cfg_cycle(idx_list[0], 1'b0, 1'b0, ~next_rand());     // en without we, ignored
      idle(2);
      run_phase(1'b1, 1'b0, 1'b0);                          // translate
      run_phase(1'b1, 1'b1, 1'b0);                          // bypass
      run_phase(1'b0, 1'b0, 1'b0);                          // disabled
      run_phase(1'b1, 1'b0, 1'b1);                          // translate under wait
      idle(4);
      if (UUT.u_assert.fail_count == 0) begin
         $display("Done: no errors");
         $finish;
      end else begin
         $display("Done: errors found");
         $fatal(1, "assertion checks failed");
      end
   end

   // stop at the first failed assertion
   initial begin
      wait (UUT.u_assert.fail_count != 0);
      $display("Done: errors found");
      $fatal(1, "an assertion in emmu_assert failed");
   end

   initial begin
      #(timeout_ns);
      $display("Done: errors found");
      $fatal(1, "watchdog timeout, the test sequence did not finish in time");
   end

endmodule

`default_nettype wire
